// File: sim.f
hdl/dcache_cfg_pkg.sv
hdl/dcache_msg_pkg.sv
hdl/dcache_data_banks.sv
hdl/dcache_tag_array.sv
hdl/dcache_fill_counter.sv
hdl/dcache_refill_fsm.sv
hdl/dcache_top.sv
tests/dcache_assert.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - hdl/dcache_cfg_pkg.sv
      - hdl/dcache_msg_pkg.sv
      - hdl/dcache_data_banks.sv
      - hdl/dcache_tag_array.sv
      - hdl/dcache_fill_counter.sv
      - hdl/dcache_refill_fsm.sv
      - hdl/dcache_top.sv
  - target: test
    files:
      - tests/dcache_assert.sv
      - tests/dcache_checker.sv
      - tests/dcache_tb.sv

// File: tests/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
();

  localparam int num_ops = 2000;
  localparam int cycle_limit = num_ops * 80;
  localparam int pool_size = 8;

  logic clk;
  logic rst;
  load_req_t load0;
  load_req_t load1;
  store_req_t store;
  load_resp_t resp0;
  load_resp_t resp1;
  logic busy;
  logic mem_req;
  logic [line_w-1:0] mem_line;
  logic mem_rvalid;
  logic [word_w-1:0] mem_rdata;
  mem_wr_t mem_wr;
  int error_count;
  int check_count;
  int cycles = 0;
  int ops_done = 0;
  logic [word_w-1:0] mem [1 << full_addr_w];
  logic [full_addr_w-1:0] pool [pool_size];
  // missed or replayed loads waiting to go again
  logic [full_addr_w-1:0] retry [$];
  logic [1:0][full_addr_w-1:0] addr_q1;
  logic [1:0][full_addr_w-1:0] addr_q2;
  logic [line_w-1:0] fill_line;
  int fill_left = 0;
  int fill_pos = 0;
  int gap_left = 0;

  dcache_top DUT (
    .clk        (clk),
    .rst        (rst),
    .load0      (load0),
    .load1      (load1),
    .store      (store),
    .resp0      (resp0),
    .resp1      (resp1),
    .busy       (busy),
    .mem_req    (mem_req),
    .mem_line   (mem_line),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .mem_wr     (mem_wr)
  );

  dcache_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .load0       (load0),
    .load1       (load1),
    .store       (store),
    .resp0       (resp0),
    .resp1       (resp1),
    .busy        (busy),
    .mem_req     (mem_req),
    .mem_line    (mem_line),
    .mem_rvalid  (mem_rvalid),
    .mem_wr      (mem_wr),
    .error_count (error_count),
    .check_count (check_count)
  );

  function automatic logic [word_w-1:0] init_word(input logic [full_addr_w-1:0] a);
    return (32'(a) * 32'h9e37_79b1) ^ 32'h5ac3_0f1d;
  endfunction

  // half from a few hot lines, half anywhere
  function automatic logic [full_addr_w-1:0] pick_addr();
    if ($urandom_range(0, 1) == 0) begin
      return pool[$urandom_range(0, pool_size - 1)];
    end
    return full_addr_w'($urandom_range(0, (1 << full_addr_w) - 1));
  endfunction

  task automatic drive_idle();
    load0 = '0;
    load1 = '0;
    store = '0;
  endtask

  task automatic issue_random();
    load0.valid = ($urandom_range(0, 9) < 7);
    load0.addr = pick_addr();
    load1.valid = ($urandom_range(0, 9) < 7);
    load1.addr = pick_addr();
    if (retry.size() > 0) begin
      load0.valid = 1'b1;
      load0.addr = retry.pop_front();
    end
    if (retry.size() > 0 && $urandom_range(0, 1) == 1) begin
      load1.valid = 1'b1;
      load1.addr = retry.pop_front();
    end
    store.valid = ($urandom_range(0, 9) < 4);
    store.addr = pick_addr();
    store.be = byte_lanes'($urandom_range(0, 15));
    store.data = $urandom;
  endtask

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // memory side handles write-through, refill requests and retries
  always @(posedge clk) begin
    if (mem_wr.valid === 1'b1) begin
      for (int i = 0; i < byte_lanes; i++) begin
        if (mem_wr.be[i]) begin
          mem[mem_wr.addr][i*8 +: 8] = mem_wr.data[i*8 +: 8];
        end
      end
    end
    if (mem_req === 1'b1) begin
      fill_line = mem_line;
      fill_left = line_words;
      fill_pos = 0;
      gap_left = $urandom_range(0, 3);
    end
    if (resp0.valid === 1'b1 && !resp0.hit) begin
      retry.push_back(addr_q2[0]);
    end
    if (resp1.valid === 1'b1 && !resp1.hit) begin
      retry.push_back(addr_q2[1]);
    end
    addr_q2 = addr_q1;
    addr_q1 = {load1.addr, load0.addr};
  end

  // refill words in ascending order with random gaps
  always @(negedge clk) begin
    mem_rvalid = 1'b0;
    if (fill_left > 0) begin
      if (gap_left > 0) begin
        gap_left--;
      end else begin
        mem_rvalid = 1'b1;
        mem_rdata = mem[{fill_line, cnt_w'(fill_pos)}];
        fill_pos++;
        fill_left--;
        gap_left = $urandom_range(0, 3);
      end
    end
  end

  initial begin : timeout
    wait (cycles >= cycle_limit);
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(32'h17b1));
    rst = 1'b1;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    drive_idle();
    for (int i = 0; i < (1 << full_addr_w); i++) begin
      mem[i] = init_word(full_addr_w'(i));
    end
    // hot lines in tag 0 and sets 0 to 7
    for (int i = 0; i < pool_size; i++) begin
      pool[i] = full_addr_w'($urandom_range(0, 127));
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (ops_done < num_ops) begin
      @(negedge clk);
      if (busy) begin
        drive_idle();
      end else begin
        issue_random();
        ops_done++;
      end
    end
    @(negedge clk);
    drive_idle();
    // let the last misses refill
    repeat (4) @(negedge clk);
    while (busy) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("errors %0d, assertion failures %0d, checks %0d", error_count,
             DUT.u_assert.fail_count, check_count);
    if (error_count == 0 && DUT.u_assert.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : dcache_tb

// File: tests/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  load_req_t         load0,
  input  load_req_t         load1,
  input  store_req_t        store,
  input  load_resp_t        resp0,
  input  load_resp_t        resp1,
  input  logic              busy,
  input  logic              mem_req,
  input  logic [line_w-1:0] mem_line,
  input  logic              mem_rvalid,
  input  mem_wr_t           mem_wr,
  output int                error_count,
  output int                check_count
);

  // what a load expects back, captured at issue
  typedef struct packed {
    logic [full_addr_w-1:0] addr;
    logic [word_w-1:0]      data;
    logic                   replay;
    logic                   need_hit;
  } pending_t;

  logic [word_w-1:0] model [1 << full_addr_w];
  pending_t pend0 [$];
  pending_t pend1 [$];
  store_req_t st_prev;
  logic st_pend;
  logic busy_prev;
  logic [line_w-1:0] exp_line;
  logic [line_w-1:0] last_line;
  logic last_ok;
  int req_count;
  int beat_count;

  // same mix as the memory responder
  function automatic logic [word_w-1:0] init_word(input logic [full_addr_w-1:0] a);
    return (32'(a) * 32'h9e37_79b1) ^ 32'h5ac3_0f1d;
  endfunction

  function automatic logic [line_w-1:0] line_of(input logic [full_addr_w-1:0] a);
    return a[full_addr_w-1 -: line_w];
  endfunction

  function automatic pending_t expect_load(input logic [full_addr_w-1:0] a, input logic rep);
    pending_t p;
    p.addr = a;
    p.data = model[a];
    p.replay = rep;
    // line refilled last and nothing since, so it must hit
    p.need_hit = last_ok && (line_of(a) == last_line);
    return p;
  endfunction

  task automatic compare_response(input int port, input load_resp_t r, input pending_t p);
    check_count++;
    if (r.replay !== p.replay) begin
      error_count++;
      $display("[FAIL] resp%0d.replay addr=%h got %h exp %h", port, p.addr, r.replay, p.replay);
    end
    if (p.need_hit && !p.replay && r.hit !== 1'b1) begin
      error_count++;
      $display("[FAIL] resp%0d.hit addr=%h got %h exp 1", port, p.addr, r.hit);
    end
    if (r.hit === 1'b1 && r.data !== p.data) begin
      error_count++;
      $display("[FAIL] resp%0d.data addr=%h got %h exp %h", port, p.addr, r.data, p.data);
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    for (int i = 0; i < (1 << full_addr_w); i++) begin
      model[i] = init_word(full_addr_w'(i));
    end
  end

  always @(posedge clk) begin : watch
    pending_t p;
    logic miss0;
    logic miss1;
    logic rep;
    logic [full_addr_w-1:0] miss_addr0;
    logic [full_addr_w-1:0] miss_addr1;
    if (rst) begin
      pend0.delete();
      pend1.delete();
      st_pend = 1'b0;
      busy_prev = 1'b0;
      last_ok = 1'b0;
      req_count = 0;
      beat_count = 0;
    end else begin
      miss0 = 1'b0;
      miss1 = 1'b0;
      miss_addr0 = '0;
      miss_addr1 = '0;
      // responses due this cycle
      if (resp0.valid) begin
        if (pend0.size() == 0) begin
          error_count++;
          $display("port 0 gave a response with no load outstanding");
        end else begin
          p = pend0.pop_front();
          compare_response(0, resp0, p);
          miss0 = !resp0.hit;
          miss_addr0 = p.addr;
        end
      end
      if (resp1.valid) begin
        if (pend1.size() == 0) begin
          error_count++;
          $display("port 1 gave a response with no load outstanding");
        end else begin
          p = pend1.pop_front();
          compare_response(1, resp1, p);
          miss1 = !resp1.hit && !resp1.replay;
          miss_addr1 = p.addr;
        end
      end
      // refill start, port 0 first
      if (busy && !busy_prev) begin
        last_ok = 1'b0;
        req_count = 0;
        beat_count = 0;
        if (miss0) begin
          exp_line = line_of(miss_addr0);
        end else if (miss1) begin
          exp_line = line_of(miss_addr1);
        end else begin
          error_count++;
          $display("busy went high without a load miss");
        end
      end
      if (mem_req) begin
        req_count++;
        check_count++;
        if (mem_line !== exp_line) begin
          error_count++;
          $display("[FAIL] mem_line got %h exp %h", mem_line, exp_line);
        end
      end
      if (mem_rvalid) begin
        beat_count++;
      end
      // refill end
      if (!busy && busy_prev) begin
        check_count++;
        if (req_count != 1) begin
          error_count++;
          $display("refill made %0d memory requests instead of one", req_count);
        end
        if (beat_count != line_words) begin
          error_count++;
          $display("busy fell after %0d returned words instead of 16", beat_count);
        end
        last_line = exp_line;
        last_ok = 1'b1;
      end
      busy_prev = busy;
      // write-through one cycle after the store
      if (st_pend) begin
        check_count++;
        if (mem_wr.valid !== 1'b1) begin
          error_count++;
          $display("[FAIL] mem_wr.valid got %h exp 1", mem_wr.valid);
        end
        if (mem_wr.addr !== st_prev.addr) begin
          error_count++;
          $display("[FAIL] mem_wr.addr got %h exp %h", mem_wr.addr, st_prev.addr);
        end
        if (mem_wr.be !== st_prev.be) begin
          error_count++;
          $display("[FAIL] mem_wr.be got %h exp %h", mem_wr.be, st_prev.be);
        end
        if (mem_wr.data !== st_prev.data) begin
          error_count++;
          $display("[FAIL] mem_wr.data got %h exp %h", mem_wr.data, st_prev.data);
        end
      end else if (mem_wr.valid === 1'b1) begin
        error_count++;
        $display("memory write appeared with no store issued the cycle before");
      end
      st_pend = store.valid && !busy;
      st_prev = store;
      // store lands before same-cycle loads read the model
      if (store.valid && !busy) begin
        for (int i = 0; i < byte_lanes; i++) begin
          if (store.be[i]) begin
            model[store.addr][i*8 +: 8] = store.data[i*8 +: 8];
          end
        end
      end
      if (!busy) begin
        // same bank, different row
        rep = load0.valid && load1.valid && (load0.addr[0] == load1.addr[0]) &&
              (load0.addr[addr_w-1:bank_w] != load1.addr[addr_w-1:bank_w]);
        if (load0.valid) begin
          pend0.push_back(expect_load(load0.addr, 1'b0));
        end
        if (load1.valid) begin
          pend1.push_back(expect_load(load1.addr, rep));
        end
      end
    end
  end

endmodule : dcache_checker

// File: tests/dcache_assert.sv
`timescale 1ns/1ns

module dcache_assert
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input load_req_t  load0,
  input load_req_t  load1,
  input load_resp_t resp0,
  input load_resp_t resp1,
  input logic       busy,
  input logic       mem_req
);

  int fail_count = 0;

  // memory request only inside a refill
  req_in_busy: assert property (@(posedge clk) disable iff (rst) mem_req |-> busy)
    else begin
      fail_count++;
      $error("mem_req seen while busy is low");
    end

  // accepted loads answer two cycles later
  resp0_latency: assert property (@(posedge clk) disable iff (rst)
    (load0.valid && !busy) |-> ##2 resp0.valid)
    else begin
      fail_count++;
      $error("port 0 load got no response two cycles later");
    end

  resp1_latency: assert property (@(posedge clk) disable iff (rst)
    (load1.valid && !busy) |-> ##2 resp1.valid)
    else begin
      fail_count++;
      $error("port 1 load got no response two cycles later");
    end

  // a replayed load never claims a hit
  replay_no_hit: assert property (@(posedge clk) disable iff (rst)
    !(resp0.replay && resp0.hit) && !(resp1.replay && resp1.hit))
    else begin
      fail_count++;
      $error("response has replay and hit set together");
    end

endmodule : dcache_assert

bind dcache_top dcache_assert u_assert (
  .clk     (clk),
  .rst     (rst),
  .load0   (load0),
  .load1   (load1),
  .resp0   (resp0),
  .resp1   (resp1),
  .busy    (busy),
  .mem_req (mem_req)
);

// File: hdl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  load_req_t         load0,
  input  load_req_t         load1,
  input  store_req_t        store,
  output load_resp_t        resp0,
  output load_resp_t        resp1,
  output logic              busy,
  output logic              mem_req,
  output logic [line_w-1:0] mem_line,
  input  logic              mem_rvalid,
  input  logic [word_w-1:0] mem_rdata,
  output mem_wr_t           mem_wr
);

  load_req_t ld0;
  load_req_t ld1;
  store_req_t st;
  logic [ways-1:0][word_w-1:0] way_data0;
  logic [ways-1:0][word_w-1:0] way_data1;
  logic conflict;
  logic hit0;
  logic hit1;
  logic [way_w-1:0] hit_way0;
  logic [way_w-1:0] hit_way1;
  logic store_hit;
  logic [way_w-1:0] store_way;
  logic [way_w-1:0] victim_way;
  logic tag_wr_done;
  logic [index_w-1:0] fill_index;
  logic [tag_w-1:0] fill_tag;
  logic commit;
  logic [cnt_w-1:0] fill_word;
  logic fill_last;
  logic fill_start;
  bank_wr_t fill_wr;
  bank_wr_t store_wr;
  bank_wr_t bank_wr;
  logic [1:0] vld_q1;
  logic [1:0] vld_q2;
  logic [1:0][full_addr_w-1:0] addr_q1;
  logic [1:0][full_addr_w-1:0] addr_q2;
  logic miss0;
  logic miss1;

  // new requests dropped during refill
  always_comb begin
    ld0 = load0;
    ld0.valid = load0.valid && !busy;
    ld1 = load1;
    ld1.valid = load1.valid && !busy;
    st = store;
    st.valid = store.valid && !busy;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr.valid <= 1'b0;
      vld_q1 <= '0;
      vld_q2 <= '0;
    end else begin
      mem_wr.valid <= st.valid;
      vld_q1 <= {ld1.valid, ld0.valid};
      vld_q2 <= vld_q1;
    end
    // write-through, hit or not
    mem_wr.addr <= st.addr;
    mem_wr.be <= st.be;
    mem_wr.data <= st.data;
    addr_q1 <= {ld1.addr, ld0.addr};
    addr_q2 <= addr_q1;
  end

  // hit store updates the array one cycle after issue
  always_comb begin
    store_wr.en = store_hit;
    store_wr.way = store_way;
    store_wr.addr = mem_wr.addr[addr_w-1:0];
    store_wr.be = mem_wr.be;
    store_wr.data = mem_wr.data;
  end

  // no stores while busy, so refill beats never collide with them
  assign bank_wr = fill_wr.en ? fill_wr : store_wr;

  always_comb begin
    resp0.valid = vld_q2[0];
    resp0.hit = hit0;
    resp0.replay = 1'b0;
    resp0.data = way_data0[hit_way0];
    resp1.valid = vld_q2[1];
    // replay only on port 1, never together with hit
    resp1.replay = conflict;
    resp1.hit = hit1 && !conflict;
    resp1.data = way_data1[hit_way1];
  end

  // a response right after the tag write may predate the new line
  assign miss0 = resp0.valid && !resp0.hit && !tag_wr_done;
  assign miss1 = resp1.valid && !resp1.hit && !resp1.replay && !tag_wr_done;

  dcache_data_banks u_banks (
    .clk       (clk),
    .rst       (rst),
    .load0     (ld0),
    .load1     (ld1),
    .wr        (bank_wr),
    .way_data0 (way_data0),
    .way_data1 (way_data1),
    .conflict  (conflict)
  );

  dcache_tag_array u_tags (
    .clk         (clk),
    .rst         (rst),
    .load0       (ld0),
    .load1       (ld1),
    .store       (st),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .commit      (commit),
    .hit0        (hit0),
    .hit1        (hit1),
    .hit_way0    (hit_way0),
    .hit_way1    (hit_way1),
    .store_hit   (store_hit),
    .store_way   (store_way),
    .victim_way  (victim_way),
    .tag_wr_done (tag_wr_done)
  );

  dcache_fill_counter u_cnt (
    .clk        (clk),
    .rst        (rst),
    .start      (fill_start),
    .mem_rvalid (mem_rvalid),
    .word       (fill_word),
    .last       (fill_last)
  );

  dcache_refill_fsm u_fsm (
    .clk        (clk),
    .rst        (rst),
    .miss0      (miss0),
    .miss_addr0 (addr_q2[0]),
    .miss1      (miss1),
    .miss_addr1 (addr_q2[1]),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .word       (fill_word),
    .last       (fill_last),
    .victim_way (victim_way),
    .busy       (busy),
    .mem_req    (mem_req),
    .mem_line   (mem_line),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .commit     (commit),
    .fill_wr    (fill_wr),
    .start      (fill_start)
  );

endmodule : dcache_top

// File: hdl/dcache_refill_fsm.sv
`timescale 1ns/1ns

module dcache_refill_fsm
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   miss0,
  input  logic [full_addr_w-1:0] miss_addr0,
  input  logic                   miss1,
  input  logic [full_addr_w-1:0] miss_addr1,
  input  logic                   mem_rvalid,
  input  logic [word_w-1:0]      mem_rdata,
  input  logic [cnt_w-1:0]       word,
  input  logic                   last,
  input  logic [way_w-1:0]       victim_way,
  output logic                   busy,
  output logic                   mem_req,
  output logic [line_w-1:0]      mem_line,
  output logic [index_w-1:0]     fill_index,
  output logic [tag_w-1:0]       fill_tag,
  output logic                   commit,
  output bank_wr_t               fill_wr,
  output logic                   start
);

  refill_state_e state;
  refill_state_e state_next;
  logic [full_addr_w-1:0] addr_q;
  logic [way_w-1:0] victim_q;
  logic miss;

  assign miss = miss0 || miss1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rf_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    // port 0 first
    if (state == rf_idle && miss) begin
      addr_q <= miss0 ? miss_addr0 : miss_addr1;
    end
    if (state == rf_request) begin
      victim_q <= victim_way;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      rf_idle: begin
        if (miss) begin
          state_next = rf_request;
        end
      end
      rf_request: state_next = rf_fill;
      rf_fill: begin
        if (last) begin
          state_next = rf_commit;
        end
      end
      rf_commit: state_next = rf_idle;
      default: state_next = rf_idle;
    endcase
  end

  // busy up in the cycle the miss shows
  assign busy = (state != rf_idle) || miss;
  assign mem_req = (state == rf_request);
  assign commit = (state == rf_commit);
  // counter cleared on the way into request
  assign start = (state == rf_idle) && miss;

  assign mem_line = addr_q[full_addr_w-1 -: line_w];
  assign fill_index = addr_q[index_lsb +: index_w];
  assign fill_tag = addr_q[addr_w +: tag_w];

  // each beat goes straight into the victim way
  always_comb begin
    fill_wr.en = (state == rf_fill) && mem_rvalid;
    fill_wr.way = victim_q;
    fill_wr.addr = {fill_index, word};
    fill_wr.be = '1;
    fill_wr.data = mem_rdata;
  end

endmodule : dcache_refill_fsm

// File: hdl/dcache_fill_counter.sv
`timescale 1ns/1ns

module dcache_fill_counter
  import dcache_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             mem_rvalid,
  output logic [cnt_w-1:0] word,
  output logic             last
);

  // word slot of the next returning beat
  always_ff @(posedge clk) begin
    if (rst || start) begin
      word <= '0;
    end else if (mem_rvalid) begin
      word <= word + 1'b1;
    end
  end

  // sixteenth word is on the bus
  assign last = mem_rvalid && (word == cnt_w'(line_words - 1));

endmodule : dcache_fill_counter

// File: hdl/dcache_tag_array.sv
`timescale 1ns/1ns

module dcache_tag_array
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  load_req_t          load0,
  input  load_req_t          load1,
  input  store_req_t         store,
  input  logic [index_w-1:0] fill_index,
  input  logic [tag_w-1:0]   fill_tag,
  input  logic               commit,
  output logic               hit0,
  output logic               hit1,
  output logic [way_w-1:0]   hit_way0,
  output logic [way_w-1:0]   hit_way1,
  output logic               store_hit,
  output logic [way_w-1:0]   store_way,
  output logic [way_w-1:0]   victim_way,
  output logic               tag_wr_done
);

  logic [ways-1:0][tag_w-1:0] tags [sets];
  logic [sets-1:0][ways-1:0] vld;
  // one round-robin bit per set picks between the two ways
  logic [sets-1:0] rr;
  logic [1:0][full_addr_w-1:0] ld_addr_q;
  logic [1:0] ld_valid_q;
  logic [1:0][ways-1:0] ld_match;
  logic [ways-1:0] st_match;

  // per-way match of one address
  function automatic logic [ways-1:0] lookup(input logic [full_addr_w-1:0] addr);
    logic [index_w-1:0] idx;
    idx = addr[index_lsb +: index_w];
    for (int w = 0; w < ways; w++) begin
      lookup[w] = vld[idx][w] && (tags[idx][w] == addr[addr_w +: tag_w]);
    end
  endfunction

  function automatic logic [way_w-1:0] encode(input logic [ways-1:0] m);
    encode = '0;
    for (int w = 0; w < ways; w++) begin
      if (m[w]) begin
        encode = way_w'(w);
      end
    end
  endfunction

  assign victim_way = rr[fill_index];

  // loads compare one cycle late, stores right away
  always_comb begin
    ld_match[0] = lookup(ld_addr_q[0]);
    ld_match[1] = lookup(ld_addr_q[1]);
    st_match = lookup(store.addr);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_valid_q <= '0;
      hit0 <= 1'b0;
      hit1 <= 1'b0;
      store_hit <= 1'b0;
      tag_wr_done <= 1'b0;
    end else begin
      ld_valid_q <= {load1.valid, load0.valid};
      hit0 <= ld_valid_q[0] && (|ld_match[0]);
      hit1 <= ld_valid_q[1] && (|ld_match[1]);
      store_hit <= store.valid && (|st_match);
      tag_wr_done <= commit;
    end
    ld_addr_q <= {load1.addr, load0.addr};
    hit_way0 <= encode(ld_match[0]);
    hit_way1 <= encode(ld_match[1]);
    store_way <= encode(st_match);
  end

  // commit fills the victim and moves the pointer on
  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
      rr <= '0;
    end else if (commit) begin
      vld[fill_index][victim_way] <= 1'b1;
      rr[fill_index] <= ~rr[fill_index];
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      tags[fill_index][victim_way] <= fill_tag;
    end
  end

endmodule : dcache_tag_array

// File: hdl/dcache_data_banks.sv
`timescale 1ns/1ns

module dcache_data_banks
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  load_req_t                    load0,
  input  load_req_t                    load1,
  input  bank_wr_t                     wr,
  output logic [ways-1:0][word_w-1:0]  way_data0,
  output logic [ways-1:0][word_w-1:0]  way_data1,
  output logic                         conflict
);

  logic [1:0][addr_w-1:0] rd_addr;
  logic [1:0][addr_w-1:0] rd_addr_q;
  // row each bank reads after arbitration
  logic [banks-1:0][bank_addr_w-1:0] bank_row;
  logic [banks-1:0][ways-1:0][word_w-1:0] bank_q;
  bank_wr_t wr_q;
  logic conflict_now;
  logic conflict_q;
  logic [1:0][ways-1:0][word_w-1:0] fwd_data;

  assign rd_addr[0] = load0.addr[addr_w-1:0];
  assign rd_addr[1] = load1.addr[addr_w-1:0];

  // same bank, different row, port 1 loses
  assign conflict_now = load0.valid && load1.valid &&
                        (rd_addr[0][bank_w-1:0] == rd_addr[1][bank_w-1:0]) &&
                        (rd_addr[0][addr_w-1:bank_w] != rd_addr[1][addr_w-1:bank_w]);

  for (genvar b = 0; b < banks; b++) begin : g_bank
    // port 0 owns the bank when valid and pointing here
    assign bank_row[b] = (load0.valid && rd_addr[0][bank_w-1:0] == b) ?
                         rd_addr[0][addr_w-1:bank_w] : rd_addr[1][addr_w-1:bank_w];

    for (genvar w = 0; w < ways; w++) begin : g_way
      logic [byte_lanes-1:0][7:0] ram [bank_depth];
      logic [word_w-1:0] q;
      logic sel;

      assign sel = wr.en && (wr.addr[bank_w-1:0] == b) && (wr.way == w);

      // byte-enabled write, one-cycle read
      always_ff @(posedge clk) begin
        for (int i = 0; i < byte_lanes; i++) begin
          if (sel && wr.be[i]) begin
            ram[wr.addr[addr_w-1:bank_w]][i] <= wr.data[i*8 +: 8];
          end
        end
        q <= ram[bank_row[b]];
      end

      assign bank_q[b][w] = q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q.en <= 1'b0;
      conflict_q <= 1'b0;
      conflict <= 1'b0;
    end else begin
      wr_q.en <= wr.en;
      conflict_q <= conflict_now;
      conflict <= conflict_q;
    end
    wr_q.way <= wr.way;
    wr_q.addr <= wr.addr;
    wr_q.be <= wr.be;
    wr_q.data <= wr.data;
    rd_addr_q <= rd_addr;
  end

  // ram output misses the write from one cycle back and the current one
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      fwd_data[p] = bank_q[rd_addr_q[p][bank_w-1:0]];
      for (int i = 0; i < byte_lanes; i++) begin
        // older write first
        if (wr_q.en && wr_q.be[i] && wr_q.addr == rd_addr_q[p]) begin
          fwd_data[p][wr_q.way][i*8 +: 8] = wr_q.data[i*8 +: 8];
        end
        // store issued with the load wins
        if (wr.en && wr.be[i] && wr.addr == rd_addr_q[p]) begin
          fwd_data[p][wr.way][i*8 +: 8] = wr.data[i*8 +: 8];
        end
      end
    end
  end

  // data lands two cycles after the load
  always_ff @(posedge clk) begin
    way_data0 <= fwd_data[0];
    way_data1 <= fwd_data[1];
  end

endmodule : dcache_data_banks

// File: hdl/dcache_msg_pkg.sv
package dcache_msg_pkg;

  import dcache_cfg_pkg::*;

  // load request, full word address
  typedef struct packed {
    logic                   valid;
    logic [full_addr_w-1:0] addr;
  } load_req_t;

  // data only meaningful with hit set
  typedef struct packed {
    logic              valid;
    logic              hit;
    logic              replay;
    logic [word_w-1:0] data;
  } load_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [full_addr_w-1:0] addr;
    logic [byte_lanes-1:0]  be;
    logic [word_w-1:0]      data;
  } store_req_t;

  // write-through to memory
  typedef struct packed {
    logic                   valid;
    logic [full_addr_w-1:0] addr;
    logic [byte_lanes-1:0]  be;
    logic [word_w-1:0]      data;
  } mem_wr_t;

  // internal data array write, in-page address
  typedef struct packed {
    logic                  en;
    logic [way_w-1:0]      way;
    logic [addr_w-1:0]     addr;
    logic [byte_lanes-1:0] be;
    logic [word_w-1:0]     data;
  } bank_wr_t;

  typedef enum logic [1:0] {
    rf_idle,
    rf_request,
    rf_fill,
    rf_commit
  } refill_state_e;

endpackage : dcache_msg_pkg

// File: hdl/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  // in-page word address: bank, row in bank, set index
  localparam int addr_w = 10;
  localparam int bank_w = 1;
  localparam int row_w = 3;
  localparam int index_w = 6;

  // page-frame bits above the in-page address
  localparam int tag_w = 4;

  localparam int ways = 2;
  localparam int line_words = 16;
  localparam int byte_lanes = 4;

  // derived sizes
  localparam int full_addr_w = tag_w + addr_w;
  localparam int word_w = byte_lanes * 8;
  localparam int banks = 1 << bank_w;
  localparam int bank_addr_w = index_w + row_w;
  localparam int bank_depth = 1 << bank_addr_w;
  localparam int sets = 1 << index_w;
  localparam int way_w = $clog2(ways);
  localparam int cnt_w = $clog2(line_words);

  // line address on the memory side is tag plus index
  localparam int line_w = tag_w + index_w;

  // start of the index field inside a word address
  localparam int index_lsb = bank_w + row_w;

endpackage : dcache_cfg_pkg
